// File: Makefile
# Verilator build and run of the board control testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 --Mdir obj_dir
TOP       = bus_ctrl_tb
FILELIST  = bus_ctrl.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "test passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/bus_ctrl_assertions.sv
// ------------------------------
// Bound checks on the top level
// LED write latency, reset values
// ------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_defs.svh"

module bus_ctrl_assertions import bus_regs_pkg::*; (
   input logic                   clk,
   input logic                   i_rst,
   input logic                   i_set_stb,
   input logic [`SR_AWIDTH-1:0]  i_set_addr,
   input logic [`DATA_W-1:0]     i_set_data,
   input logic [`LED_W-1:0]      o_leds,
   input logic [`CLK_CTRL_W-1:0] o_clock_control,
   input logic [1:0]             o_sfpp0_rs_drv,
   input logic [1:0]             o_sfpp1_rs_drv
);

   // LED write shows next cycle
   assert property (@(posedge clk) disable iff (i_rst)
      (i_set_stb && i_set_addr == SR_LEDS) |=> (o_leds == $past(i_set_data[`LED_W-1:0])))
      else $error("LED register did not take the written value");

   // Clock control reset value
   assert property (@(posedge clk) i_rst |=> (o_clock_control == `CLK_CTRL_RESET))
      else $error("clock control not at its reset value after reset");

   // Rate select released in reset
   assert property (@(posedge clk) i_rst |=> (o_sfpp0_rs_drv == 2'b00 && o_sfpp1_rs_drv == 2'b00))
      else $error("rate select drives not zero after reset");

endmodule

bind bus_ctrl_top bus_ctrl_assertions u_assertions (
   .clk             (clk),
   .i_rst           (i_rst),
   .i_set_stb       (i_set_stb),
   .i_set_addr      (i_set_addr),
   .i_set_data      (i_set_data),
   .o_leds          (o_leds),
   .o_clock_control (o_clock_control),
   .o_sfpp0_rs_drv  (o_sfpp0_rs_drv),
   .o_sfpp1_rs_drv  (o_sfpp1_rs_drv)
);

// File: bench/bus_ctrl_tb.sv
// ------------------------------
// Board control block testbench
// Random writes, reads and cage pin changes vs a model
// ------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_defs.svh"

module bus_ctrl_tb import bus_regs_pkg::*; import sfpp_pkg::*; ();

   localparam int PERIOD  = 100;
   localparam int N_WR    = 40;
   localparam int N_CONST = 8;
   localparam int N_CNT   = 8;
   localparam int N_SFP   = 40;
   // Reset, reset checks, then each test loop
   localparam int TEST_CYCLES = 3 + 6 + N_WR*3 + N_CONST*12 + N_CNT*18 + N_SFP*12;
   localparam int MARGIN      = 100;

   logic        clk;
   logic        i_rst;
   logic        i_set_stb;
   logic [7:0]  i_set_addr;
   logic [31:0] i_set_data;
   logic [7:0]  i_rb_addr;
   logic        i_rb_rd_stb;
   logic [31:0] o_rb_data;
   logic [7:0]  i_clock_status;
   logic [6:0]  o_clock_control;
   logic [7:0]  o_leds;
   logic [3:0]  o_sw_rst;
   sfpp_pins_t  i_sfpp0_pins;
   sfpp_pins_t  i_sfpp1_pins;
   logic [15:0] i_eth0_phy_status;
   logic [15:0] i_eth1_phy_status;
   logic [1:0]  o_sfpp0_rs_drv;
   logic [1:0]  o_sfpp1_rs_drv;

   integer seed;
   int     n_checks;
   int     n_errors;

   // ------------------------------
   // Reference model state
   // ------------------------------
   logic [7:0]  leds_m;
   logic [3:0]  sw_rst_m;
   logic [6:0]  clk_ctrl_m;
   logic [1:0]  rs0_m;
   logic [1:0]  rs1_m;
   logic [31:0] cnt_model;
   // Per cage pin history and flags
   sfpp_pins_t  pins_m  [2];
   sfpp_pins_t  flags_m [2];
   logic [15:0] phy_m   [2];

   bus_ctrl_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   // Zero in reset, then one per cycle
   always @(posedge clk) begin
      if (i_rst) begin
         cnt_model <= '0;
      end else begin
         cnt_model <= cnt_model + 32'd1;
      end
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      n_checks++;
      if (actual !== expected) begin
         n_errors++;
         $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   // All config outputs against shadows
   task automatic check_regs(input string name);
      check_value({name, " leds"}, 32'(leds_m), 32'(o_leds));
      check_value({name, " sw_rst"}, 32'(sw_rst_m), 32'(o_sw_rst));
      check_value({name, " clock_control"}, 32'(clk_ctrl_m), 32'(o_clock_control));
      check_value({name, " rs0"}, 32'(rs0_m), 32'(o_sfpp0_rs_drv));
      check_value({name, " rs1"}, 32'(rs1_m), 32'(o_sfpp1_rs_drv));
   endtask

   // One strobe, check one cycle later
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      i_set_stb  <= 1'b1;
      i_set_addr <= addr;
      i_set_data <= data;
      @(posedge clk);
      i_set_stb  <= 1'b0;
      case (addr)
         SR_LEDS:       leds_m     = data[7:0];
         SR_SW_RST:     sw_rst_m   = data[3:0];
         SR_CLOCK_CTRL: clk_ctrl_m = data[6:0];
         SR_SFPP_CTRL0: rs0_m      = data[1:0];
         SR_SFPP_CTRL1: rs1_m      = data[1:0];
         default:       ;
      endcase
      @(negedge clk);
      check_regs($sformatf("write %02h", addr));
   endtask

   // Address for one cycle, data taken mid cycle
   task automatic read_word(input logic [7:0] addr, input logic stb, output logic [31:0] data);
      @(posedge clk);
      i_rb_addr   <= addr;
      i_rb_rd_stb <= stb;
      @(negedge clk);
      data = o_rb_data;
      @(posedge clk);
      i_rb_rd_stb <= 1'b0;
   endtask

   // Decode a cage word by field
   task automatic check_sfpp(input int cage, input logic clear);
      logic [31:0] data;
      sfpp_word_u  w;
      read_word(cage != 0 ? RB_SFPP_STATUS1 : RB_SFPP_STATUS0, clear, data);
      w.raw = data;
      check_value($sformatf("sfpp%0d phy", cage), 32'(phy_m[cage]), 32'(w.fields.phy));
      check_value($sformatf("sfpp%0d rsvd", cage), 32'h0, 32'(w.fields.rsvd));
      check_value($sformatf("sfpp%0d chgd", cage), 32'(flags_m[cage]), 32'(w.fields.chgd));
      check_value($sformatf("sfpp%0d pins", cage), 32'(pins_m[cage]), 32'(w.fields.pins));
      if (clear) begin
         flags_m[cage] = '0;
      end
   endtask

   initial begin
      int          i;
      int          k;
      logic [31:0] r;
      logic [31:0] data;
      logic [31:0] c1;
      logic [31:0] c2;
      sfpp_pins_t  mask0;
      sfpp_pins_t  mask1;
      seed = 32'h4d0f_0c5f;
      n_checks = 0;
      n_errors = 0;
      i_rst = 1'b1;
      i_set_stb = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      i_rb_addr = '0;
      i_rb_rd_stb = 1'b0;
      i_clock_status = '0;
      i_sfpp0_pins = '0;
      i_sfpp1_pins = '0;
      i_eth0_phy_status = '0;
      i_eth1_phy_status = '0;
      leds_m = '0;
      sw_rst_m = '0;
      clk_ctrl_m = 7'b100_0000;
      rs0_m = '0;
      rs1_m = '0;
      for (i = 0; i < 2; i++) begin
         pins_m[i] = '0;
         flags_m[i] = '0;
         phy_m[i] = '0;
      end
      repeat (3) @(posedge clk);
      i_rst <= 1'b0;
      @(negedge clk);

      // ------------------------------
      // State after reset
      // ------------------------------
      check_regs("reset");
      check_sfpp(0, 1'b0);
      check_sfpp(1, 1'b0);

      // Mapped and unmapped writes
      for (i = 0; i < N_WR; i++) begin
         r = $random(seed);
         write_setting({4'h0, r[3:0]}, $random(seed));
      end

      // Fixed words and clock status
      for (i = 0; i < N_CONST; i++) begin
         r = $random(seed);
         @(posedge clk);
         i_clock_status <= r[7:0];
         read_word(RB_CLK_STATUS, 1'b0, data);
         check_value("clk status", {24'h0, r[7:0]}, data);
         read_word(RB_COMPAT_NUM, 1'b0, data);
         check_value("compat num", {16'd13, 16'd0}, data);
         read_word(RB_ETH_TYPE0, 1'b0, data);
         check_value("eth type0", `ETH_TYPE0, data);
         read_word(RB_ETH_TYPE1, 1'b0, data);
         check_value("eth type1", `ETH_TYPE1, data);
         read_word(8'h10 | r[23:16], 1'b0, data);
         check_value("unmapped", 32'h0, data);
      end

      // Counter step over k cycles
      for (i = 0; i < N_CNT; i++) begin
         r = $random(seed);
         k = 1 + int'(r[3:0]);
         @(posedge clk);
         i_rb_addr <= RB_COUNTER;
         @(negedge clk);
         c1 = o_rb_data;
         check_value("counter model", cnt_model, c1);
         repeat (k) @(negedge clk);
         c2 = o_rb_data;
         check_value("counter step", k, c2 - c1);
      end

      // ------------------------------
      // Cage pins, flags, read clear
      // ------------------------------
      for (i = 0; i < N_SFP; i++) begin
         r = $random(seed);
         // Sparse toggles
         mask0 = sfpp_pins_t'(r[2:0] & r[5:3]);
         mask1 = sfpp_pins_t'(r[8:6] & r[11:9]);
         r = $random(seed);
         @(posedge clk);
         i_sfpp0_pins      <= pins_m[0] ^ mask0;
         i_sfpp1_pins      <= pins_m[1] ^ mask1;
         i_eth0_phy_status <= r[15:0];
         i_eth1_phy_status <= r[31:16];
         pins_m[0]  = pins_m[0] ^ mask0;
         pins_m[1]  = pins_m[1] ^ mask1;
         flags_m[0] = flags_m[0] | mask0;
         flags_m[1] = flags_m[1] | mask1;
         phy_m[0]   = r[15:0];
         phy_m[1]   = r[31:16];
         // Quiet cycles through sync and flag
         repeat (4) @(posedge clk);
         r = $random(seed);
         check_sfpp(int'(r[0]), r[1]);
         if (r[1]) begin
            check_sfpp(int'(r[0]), 1'b0);
         end
         // Other cage keeps its flags
         check_sfpp(int'(!r[0]), 1'b0);
      end

      $display("checks run %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // Run length bound
   initial begin
      #((TEST_CYCLES + MARGIN) * PERIOD);
      $display("watchdog timeout, tests did not complete in time");
      $display("test failed");
      $finish;
   end

endmodule

// File: bus_ctrl.f
+incdir+hdl
hdl/bus_regs_pkg.sv
hdl/sfpp_pkg.sv
hdl/sfpp_status_if.sv
hdl/ctrl_regs.sv
hdl/sfpp_status_mon.sv
hdl/readback_mux.sv
hdl/bus_ctrl_top.sv
bench/bus_ctrl_assertions.sv
bench/bus_ctrl_tb.sv

// File: hdl/bus_ctrl_defs.svh
// ------------------------------
// Board control bus constants
// Widths, reset values, IDs
// ------------------------------
`ifndef BUS_CTRL_DEFS_SVH
`define BUS_CTRL_DEFS_SVH

// Bus widths
`define SR_AWIDTH 8
`define RB_AWIDTH 8
`define DATA_W 32

// Status and control widths
`define PHY_STATUS_W 16
`define CLK_STATUS_W 8
`define CLK_CTRL_W 7
`define SW_RST_W 4
`define LED_W 8

// Bit 6 high, GPSDO on out of reset
`define CLK_CTRL_RESET 7'b100_0000

// Two flops per async input
`define SYNC_STAGES 2

// Compatibility number reported to host
`define COMPAT_MAJOR 16'h000D
`define COMPAT_MINOR 16'h0000

// ------------------------------
// Ethernet port type per build
// ------------------------------
// 0 for 1G, 1 for a 10G port
`define ETH_TYPE0 32'h0000_0000
`define ETH_TYPE1 32'h0000_0000

`endif

// File: hdl/bus_ctrl_top.sv
// ------------------------------
// Board control register block
// ------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_defs.svh"

module bus_ctrl_top import sfpp_pkg::*; (
   input  logic                     clk,
   input  logic                     i_rst,
   // Settings bus
   input  logic                     i_set_stb,
   input  logic [`SR_AWIDTH-1:0]    i_set_addr,
   input  logic [`DATA_W-1:0]       i_set_data,
   // Readback bus
   input  logic [`RB_AWIDTH-1:0]    i_rb_addr,
   input  logic                     i_rb_rd_stb,
   output logic [`DATA_W-1:0]       o_rb_data,
   // Clock board
   input  logic [`CLK_STATUS_W-1:0] i_clock_status,
   output logic [`CLK_CTRL_W-1:0]   o_clock_control,
   // Board misc
   output logic [`LED_W-1:0]        o_leds,
   output logic [`SW_RST_W-1:0]     o_sw_rst,
   // SFP+ cages
   input  sfpp_pins_t               i_sfpp0_pins,
   input  sfpp_pins_t               i_sfpp1_pins,
   input  logic [`PHY_STATUS_W-1:0] i_eth0_phy_status,
   input  logic [`PHY_STATUS_W-1:0] i_eth1_phy_status,
   output logic [1:0]               o_sfpp0_rs_drv,
   output logic [1:0]               o_sfpp1_rs_drv
);

   // Cage status links
   sfpp_status_if st0_if ();
   sfpp_status_if st1_if ();

   // ------------------------------
   // Config registers
   // ------------------------------
   ctrl_regs u_ctrl_regs (
      .clk             (clk),
      .i_rst           (i_rst),
      .i_set_stb       (i_set_stb),
      .i_set_addr      (i_set_addr),
      .i_set_data      (i_set_data),
      .o_leds          (o_leds),
      .o_sw_rst        (o_sw_rst),
      .o_clock_control (o_clock_control),
      .o_sfpp0_rs_drv  (o_sfpp0_rs_drv),
      .o_sfpp1_rs_drv  (o_sfpp1_rs_drv)
   );

   // ------------------------------
   // Cage monitors
   // ------------------------------
   sfpp_status_mon u_sfpp0_mon (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_pins       (i_sfpp0_pins),
      .i_phy_status (i_eth0_phy_status),
      .status       (st0_if.mon)
   );

   sfpp_status_mon u_sfpp1_mon (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_pins       (i_sfpp1_pins),
      .i_phy_status (i_eth1_phy_status),
      .status       (st1_if.mon)
   );

   // Readback select
   readback_mux u_readback_mux (
      .clk            (clk),
      .i_rst          (i_rst),
      .i_rb_addr      (i_rb_addr),
      .i_rb_rd_stb    (i_rb_rd_stb),
      .o_rb_data      (o_rb_data),
      .i_clock_status (i_clock_status),
      .st0            (st0_if.rb),
      .st1            (st1_if.rb)
   );

endmodule

// File: hdl/bus_regs_pkg.sv
// ------------------------------
// Settings and readback address maps
// ------------------------------
`include "bus_ctrl_defs.svh"

package bus_regs_pkg;

   // ------------------------------
   // Settings bus register map
   // ------------------------------
   typedef enum logic [`SR_AWIDTH-1:0] {
      // LED drive bits
      SR_LEDS       = `SR_AWIDTH'(0),
      // Soft resets
      // [0] PHY, [1] radio clk domain, [2] radio PLL, [3] ADC idelayctrl
      SR_SW_RST     = `SR_AWIDTH'(1),
      // Clock board control
      SR_CLOCK_CTRL = `SR_AWIDTH'(2),
      // Rate select per cage
      SR_SFPP_CTRL0 = `SR_AWIDTH'(8),
      SR_SFPP_CTRL1 = `SR_AWIDTH'(9)
   } sr_addr_e;

   // ------------------------------
   // Readback bus word map
   // ------------------------------
   typedef enum logic [`RB_AWIDTH-1:0] {
      // Free running cycle count
      RB_COUNTER      = `RB_AWIDTH'(0),
      // Clock board status, low byte
      RB_CLK_STATUS   = `RB_AWIDTH'(3),
      // Ethernet type per port
      RB_ETH_TYPE0    = `RB_AWIDTH'(4),
      RB_ETH_TYPE1    = `RB_AWIDTH'(5),
      // Major and minor compat
      RB_COMPAT_NUM   = `RB_AWIDTH'(6),
      // Cage status, flags clear on read
      RB_SFPP_STATUS0 = `RB_AWIDTH'(8),
      RB_SFPP_STATUS1 = `RB_AWIDTH'(9)
   } rb_addr_e;

endpackage

// File: hdl/ctrl_regs.sv
// ------------------------------
// Settings bus config registers
// ------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_defs.svh"

module ctrl_regs import bus_regs_pkg::*; (
   input  logic                   clk,
   input  logic                   i_rst,
   // Settings bus
   input  logic                   i_set_stb,
   input  logic [`SR_AWIDTH-1:0]  i_set_addr,
   input  logic [`DATA_W-1:0]     i_set_data,
   // Register outputs
   output logic [`LED_W-1:0]      o_leds,
   output logic [`SW_RST_W-1:0]   o_sw_rst,
   output logic [`CLK_CTRL_W-1:0] o_clock_control,
   // Rate select pull-low enables
   output logic [1:0]             o_sfpp0_rs_drv,
   output logic [1:0]             o_sfpp1_rs_drv
);

   // Address as a map entry
   sr_addr_e set_addr;

   assign set_addr = sr_addr_e'(i_set_addr);

   // ------------------------------
   // Register writes
   // ------------------------------
   // Value shows one cycle after the strobe
   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_leds          <= '0;
         o_sw_rst        <= '0;
         // GPSDO enabled out of reset
         o_clock_control <= `CLK_CTRL_RESET;
         // Rate select pins float
         o_sfpp0_rs_drv  <= 2'b00;
         o_sfpp1_rs_drv  <= 2'b00;
      end else if (i_set_stb) begin
         // Low bits of the data word only
         case (set_addr)
            SR_LEDS: begin
               o_leds <= i_set_data[`LED_W-1:0];
            end
            SR_SW_RST: begin
               o_sw_rst <= i_set_data[`SW_RST_W-1:0];
            end
            SR_CLOCK_CTRL: begin
               o_clock_control <= i_set_data[`CLK_CTRL_W-1:0];
            end
            // Bit set pulls RS0 or RS1 low
            SR_SFPP_CTRL0: begin
               o_sfpp0_rs_drv <= i_set_data[1:0];
            end
            SR_SFPP_CTRL1: begin
               o_sfpp1_rs_drv <= i_set_data[1:0];
            end
            // Other addresses belong elsewhere
            default: begin
            end
         endcase
      end
   end

endmodule

// File: hdl/readback_mux.sv
// ------------------------------
// Readback word select
// Counter, status words, read clear
// ------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_defs.svh"

module readback_mux import bus_regs_pkg::*; import sfpp_pkg::*; (
   input  logic                     clk,
   input  logic                     i_rst,
   // Readback bus
   input  logic [`RB_AWIDTH-1:0]    i_rb_addr,
   input  logic                     i_rb_rd_stb,
   output logic [`DATA_W-1:0]       o_rb_data,
   // Clock board status
   input  logic [`CLK_STATUS_W-1:0] i_clock_status,
   // Cage status
   sfpp_status_if.rb                st0,
   sfpp_status_if.rb                st1
);

   // Address as a map entry
   rb_addr_e rb_addr;
   // Cycle counter
   logic [`DATA_W-1:0] counter;
   // Assembled cage words
   sfpp_word_u sfpp0_word;
   sfpp_word_u sfpp1_word;

   assign rb_addr = rb_addr_e'(i_rb_addr);

   // Fill the status layout, send out raw
   function automatic sfpp_word_u build_sfpp_word(
      input logic [`PHY_STATUS_W-1:0] phy,
      input sfpp_pins_t               chgd,
      input sfpp_pins_t               pins
   );
      sfpp_word_u w;
      w.fields.phy  = phy;
      w.fields.rsvd = '0;
      w.fields.chgd = chgd;
      w.fields.pins = pins;
      return w;
   endfunction

   // ------------------------------
   // Free running counter
   // ------------------------------
   always_ff @(posedge clk) begin
      if (i_rst) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   assign sfpp0_word = build_sfpp_word(st0.phy, st0.chgd, st0.pins);
   assign sfpp1_word = build_sfpp_word(st1.phy, st1.chgd, st1.pins);

   // ------------------------------
   // Word select
   // ------------------------------
   // Same cycle as the address
   always_comb begin
      case (rb_addr)
         RB_COUNTER:      o_rb_data = counter;
         RB_CLK_STATUS:   o_rb_data = {{(`DATA_W-`CLK_STATUS_W){1'b0}}, i_clock_status};
         RB_ETH_TYPE0:    o_rb_data = `ETH_TYPE0;
         RB_ETH_TYPE1:    o_rb_data = `ETH_TYPE1;
         RB_COMPAT_NUM:   o_rb_data = {`COMPAT_MAJOR, `COMPAT_MINOR};
         RB_SFPP_STATUS0: o_rb_data = sfpp0_word.raw;
         RB_SFPP_STATUS1: o_rb_data = sfpp1_word.raw;
         // Unmapped reads as zero
         default:         o_rb_data = '0;
      endcase
   end

   // Reading a cage word clears its flags next edge
   assign st0.clr = i_rb_rd_stb && (rb_addr == RB_SFPP_STATUS0);
   assign st1.clr = i_rb_rd_stb && (rb_addr == RB_SFPP_STATUS1);

endmodule

// File: hdl/sfpp_pkg.sv
// ------------------------------
// SFP+ cage pin and status types
// ------------------------------
`include "bus_ctrl_defs.svh"

package sfpp_pkg;

   // Cage pins, MSB first as read back
   typedef struct packed {
      // Module absent
      logic mod_abs;
      // Transmit fault
      logic tx_fault;
      // Receive loss of signal
      logic rx_los;
   } sfpp_pins_t;

   // ------------------------------
   // Status word layout
   // ------------------------------
   typedef struct packed {
      // Synchronized PHY status, bits 31..16
      logic [`PHY_STATUS_W-1:0] phy;
      // Always zero
      logic [9:0]               rsvd;
      // Sticky change flags, bits 5..3
      sfpp_pins_t               chgd;
      // Synchronized pins, bits 2..0
      sfpp_pins_t               pins;
   } sfpp_status_t;

   // Same word seen raw or by field
   typedef union packed {
      logic [`DATA_W-1:0] raw;
      sfpp_status_t       fields;
   } sfpp_word_u;

endpackage

// File: hdl/sfpp_status_if.sv
// ------------------------------
// One cage's status to readback
// ------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_defs.svh"

interface sfpp_status_if import sfpp_pkg::*; ();

   // Synchronized pins
   sfpp_pins_t               pins;
   // Sticky change flags
   sfpp_pins_t               chgd;
   // Synchronized PHY status
   logic [`PHY_STATUS_W-1:0] phy;
   // Read clear strobe back to the monitor
   logic                     clr;

   // Monitor side
   modport mon (
      output pins, chgd, phy,
      input  clr
   );

   // Readback side
   modport rb (
      input  pins, chgd, phy,
      output clr
   );

endinterface

// File: hdl/sfpp_status_mon.sv
// ------------------------------
// SFP+ cage monitor
// Syncs pins and PHY status and latches pin changes
// ------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_defs.svh"

module sfpp_status_mon import sfpp_pkg::*; (
   input  logic                     clk,
   input  logic                     i_rst,
   // Async cage pins
   input  sfpp_pins_t               i_pins,
   // Async PHY status bits
   input  logic [`PHY_STATUS_W-1:0] i_phy_status,
   // Status out and clear in
   sfpp_status_if.mon               status
);

   // Synchronizer stages
   sfpp_pins_t               pin_sync [`SYNC_STAGES];
   logic [`PHY_STATUS_W-1:0] phy_sync [`SYNC_STAGES];

   // Last synchronized pins
   sfpp_pins_t pins_now;
   // Pins one cycle earlier
   sfpp_pins_t pins_prev;
   // Sticky flags
   sfpp_pins_t chgd;

   // ------------------------------
   // Synchronizers
   // ------------------------------
   // Each input shifts down its chain
   always_ff @(posedge clk) begin
      pin_sync[0] <= i_pins;
      phy_sync[0] <= i_phy_status;
      for (int s = 1; s < `SYNC_STAGES; s++) begin
         pin_sync[s] <= pin_sync[s-1];
         phy_sync[s] <= phy_sync[s-1];
      end
   end

   assign pins_now = pin_sync[`SYNC_STAGES-1];

   // ------------------------------
   // Change detect
   // ------------------------------
   always_ff @(posedge clk) begin
      if (i_rst) begin
         pins_prev <= '0;
         chgd      <= '0;
      end else begin
         pins_prev <= pins_now;
         // Clear wins over a change in the same cycle
         if (status.clr) begin
            chgd <= '0;
         end else begin
            chgd <= chgd | (pins_now ^ pins_prev);
         end
      end
   end

   // To readback
   assign status.pins = pins_now;
   assign status.chgd = chgd;
   assign status.phy  = phy_sync[`SYNC_STAGES-1];

endmodule
